//--- include/filter_params.svh
// ==========================================================
// Build-time sizes of the counting filter
// Included by the packages and by any module that sizes an
// array or a pipeline from these values
// ==========================================================

`ifndef FILTER_PARAMS_SVH
`define FILTER_PARAMS_SVH

// Number of buckets held in the filter
`define FILTER_N_BUCKETS 16

// Width of one bucket counter
`define FILTER_BUCKET_BITS 4

// Entries in the remove request queue (a power of two)
`define FILTER_REMOVE_DEPTH 4

// Cycles from the update read to the memory write
`define FILTER_UPD_STAGES 2

`endif

//--- design/filter_pkg.sv
// ==========================================================
// Types that describe the filter contents
// Bucket addresses, bucket counts and the signed correction
// applied to a read value by the update bypass
// ==========================================================

`include "filter_params.svh"

package filter_pkg;

    // Address of one bucket
    typedef logic [$clog2(`FILTER_N_BUCKETS)-1:0] bucket_idx_t;

    // Count stored in one bucket
    typedef logic [`FILTER_BUCKET_BITS-1:0] bucket_value_t;

    // Net change from the updates in flight, -3 up to +3
    // Arithmetic wraps at the counter width just like the buckets do
    typedef logic signed [`FILTER_BUCKET_BITS-1:0] bucket_delta_t;

endpackage

//--- design/storage_pkg.sv
// ==========================================================
// Types that describe the storage building blocks
// Used by the clearing memory and by the remove queue
// ==========================================================

`include "filter_params.svh"

package storage_pkg;

    // Memory sweep state after reset
    typedef enum logic
    {
        RAM_CLEAR,
        RAM_READY
    } ram_state_t;

    // Occupancy of the remove queue, 0 up to full
    typedef logic [$clog2(`FILTER_REMOVE_DEPTH+1)-1:0] fifo_count_t;

endpackage

//--- design/bucket_ram.sv
// ==========================================================
// Simple dual-port bucket memory with a clearing sweep
// One registered read port and one write port. After reset
// every address is written with zero, then rdy goes high
// ==========================================================

`timescale 1ns/1ps
`include "filter_params.svh"

module bucket_ram
    import filter_pkg::*;
    import storage_pkg::*;
#(
    parameter int DATA_BITS = `FILTER_BUCKET_BITS
)
(
    input  logic                 clk,
    input  logic                 reset,
    output logic                 rdy,
    input  bucket_idx_t          raddr,
    output logic [DATA_BITS-1:0] rdata,
    input  logic                 wen,
    input  bucket_idx_t          waddr,
    input  logic [DATA_BITS-1:0] wdata
);

    logic [DATA_BITS-1:0] mem [`FILTER_N_BUCKETS];

    ram_state_t           state;
    bucket_idx_t          clr_idx;

    // Write port after the sweep mux
    logic                 mem_we;
    bucket_idx_t          mem_waddr;
    logic [DATA_BITS-1:0] mem_wdata;

    // The sweep visits one address per cycle and stops on the last
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state   <= RAM_CLEAR;
            clr_idx <= '0;
        end
        else if (state == RAM_CLEAR)
        begin
            clr_idx <= clr_idx + 1'b1;
            if (clr_idx == bucket_idx_t'(`FILTER_N_BUCKETS - 1))
            begin
                state <= RAM_READY;
            end
        end
    end

    assign rdy = (state == RAM_READY);

    // While clearing, the sweep owns the write port
    assign mem_we    = (state == RAM_CLEAR) || wen;
    assign mem_waddr = (state == RAM_CLEAR) ? clr_idx : waddr;
    assign mem_wdata = (state == RAM_CLEAR) ? '0 : wdata;

    // A read and a write to one address in the same cycle return the old value
    always_ff @(posedge clk)
    begin
        rdata <= mem[raddr];
        if (mem_we)
        begin
            mem[mem_waddr] <= mem_wdata;
        end
    end

    // Clients hold off until rdy, so nothing may write during the sweep
    a_no_write_while_clearing: assert property (
        @(posedge clk) disable iff (reset) (state == RAM_CLEAR) |-> !wen
    ) else $error("write to bucket memory during the clearing sweep");

endmodule

//--- design/remove_fifo.sv
// ==========================================================
// Small FIFO that buffers remove requests
// Ring buffer with an occupancy count and a registered head,
// so first is valid in the same cycle that not_empty rises
// ==========================================================

`timescale 1ns/1ps
`include "filter_params.svh"

module remove_fifo
    import filter_pkg::*;
    import storage_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        enq_en,
    input  bucket_idx_t enq_data,
    output logic        not_full,
    output bucket_idx_t first,
    output logic        not_empty,
    input  logic        deq_en
);

    // Pointers wrap on their own since the depth is a power of two
    typedef logic [$clog2(`FILTER_REMOVE_DEPTH)-1:0] ptr_t;

    bucket_idx_t buf_mem [`FILTER_REMOVE_DEPTH];
    ptr_t        wr_ptr;
    ptr_t        rd_ptr;
    ptr_t        rd_ptr_inc;
    fifo_count_t count;
    logic        head_empty;

    assign rd_ptr_inc = rd_ptr + 1'b1;
    assign not_full   = (count != fifo_count_t'(`FILTER_REMOVE_DEPTH));
    assign not_empty  = (count != '0);

    // True when no older entry remains after this cycle's dequeue
    assign head_empty = (count == fifo_count_t'(deq_en));

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (enq_en)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (deq_en)
            begin
                rd_ptr <= rd_ptr_inc;
            end
            count <= count + fifo_count_t'(enq_en) - fifo_count_t'(deq_en);
        end
    end

    // Head register follows the oldest entry
    // A new entry lands straight in the head when the queue drains to it
    always_ff @(posedge clk)
    begin
        if (enq_en)
        begin
            buf_mem[wr_ptr] <= enq_data;
        end
        if (enq_en && head_empty)
        begin
            first <= enq_data;
        end
        else if (deq_en)
        begin
            first <= buf_mem[rd_ptr_inc];
        end
    end

    a_no_enq_when_full: assert property (
        @(posedge clk) disable iff (reset) enq_en |-> not_full
    ) else $error("remove request enqueued while the queue is full");

    a_no_deq_when_empty: assert property (
        @(posedge clk) disable iff (reset) deq_en |-> not_empty
    ) else $error("remove request taken from an empty queue");

endmodule

//--- design/lookup_port.sv
// ==========================================================
// Lookup pipeline on a private copy of the bucket memory
// A request in cycle t returns its result in cycle t+2.
// Writes from the update pipeline that land while the
// request is in flight are captured and win over memory data
// ==========================================================

`timescale 1ns/1ps
`include "filter_params.svh"

module lookup_port
    import filter_pkg::*;
#(
    parameter int DATA_BITS = `FILTER_BUCKET_BITS
)
(
    input  logic                 clk,
    input  logic                 reset,
    output logic                 rdy,
    input  bucket_idx_t          req,
    output logic [DATA_BITS-1:0] result,
    input  logic                 wr_en,
    input  bucket_idx_t          wr_idx,
    input  logic [DATA_BITS-1:0] wr_data
);

    // Lookup depth matches the update distance from read to write
    localparam int LAST = `FILTER_UPD_STAGES;

    // Per-stage request index and captured write, stage 0 is combinational
    bucket_idx_t          idx     [0:LAST];
    logic                 hit     [0:LAST];
    logic [DATA_BITS-1:0] hit_val [0:LAST];

    logic [DATA_BITS-1:0] mem_rdata;
    logic [DATA_BITS-1:0] mem_q;

    bucket_ram #(
        .DATA_BITS (DATA_BITS)
    ) mem (
        .clk   (clk),
        .reset (reset),
        .rdy   (rdy),
        .raddr (req),
        .rdata (mem_rdata),
        .wen   (wr_en),
        .waddr (wr_idx),
        .wdata (wr_data)
    );

    // A write in the request cycle is not seen by the memory read
    assign idx[0]     = req;
    assign hit[0]     = wr_en && (req == wr_idx);
    assign hit_val[0] = wr_data;

    // Each later stage checks the write of its own cycle, newest write wins
    for (genvar p = 1; p <= LAST; p++)
    begin : g_stage
        always_ff @(posedge clk)
        begin
            idx[p] <= idx[p-1];
            if (wr_en && (idx[p-1] == wr_idx))
            begin
                hit_val[p] <= wr_data;
            end
            else
            begin
                hit_val[p] <= hit_val[p-1];
            end

            if (reset)
            begin
                hit[p] <= 1'b0;
            end
            else
            begin
                hit[p] <= hit[p-1] || (wr_en && (idx[p-1] == wr_idx));
            end
        end
    end

    // Memory data is one cycle old, so align it with the last stage
    always_ff @(posedge clk)
    begin
        mem_q <= mem_rdata;
    end

    assign result = hit[LAST] ? hit_val[LAST] : mem_q;

endmodule

//--- design/update_pipeline.sv
// ==========================================================
// Read-modify-write pipeline for bucket updates
// Stage 0 picks insert over a queued remove and reads the
// memory, stage 1 forms the delta against older updates in
// flight, and stage 2 writes. The write lines also feed the
// lookup ports
// ==========================================================

`timescale 1ns/1ps
`include "filter_params.svh"

module update_pipeline
    import filter_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    output logic          rdy,
    input  logic          insert_en,
    input  bucket_idx_t   insert,
    input  logic          remove_valid,
    input  bucket_idx_t   remove_head,
    output logic          remove_take,
    output logic          wr_en,
    output bucket_idx_t   wr_idx,
    output bucket_value_t wr_val
);

    // Write stage, plus one extra stage whose write the stage 1 read missed
    localparam int WR   = `FILTER_UPD_STAGES;
    localparam int LAST = WR + 1;

    logic          upd_en  [0:LAST];
    bucket_idx_t   upd_idx [0:LAST];
    logic          upd_ins [0:LAST];

    bucket_value_t rd_val;
    bucket_delta_t upd_delta;
    bucket_value_t upd_sum;
    bucket_value_t wr_val_q;

    // Shadow copy of the counters used only by the checks below
    bucket_value_t shadow [`FILTER_N_BUCKETS];
    bucket_value_t shadow_cur;
    bucket_value_t shadow_next;

    // Change that one update makes to its bucket
    function automatic bucket_delta_t op_step(input logic is_insert);
        return is_insert ? bucket_delta_t'(1) : bucket_delta_t'(-1);
    endfunction

    // ======================================================
    // Stage 0 arbitration and memory read
    // ======================================================

    // One port, insert first. Nothing issues until the sweep is done
    always_comb
    begin
        remove_take = rdy && !insert_en && remove_valid;
        upd_en[0]   = rdy && (insert_en || remove_valid);
        upd_idx[0]  = insert_en ? insert : remove_head;
        upd_ins[0]  = insert_en;
    end

    bucket_ram #(
        .DATA_BITS (`FILTER_BUCKET_BITS)
    ) mem (
        .clk   (clk),
        .reset (reset),
        .rdy   (rdy),
        .raddr (upd_idx[0]),
        .rdata (rd_val),
        .wen   (wr_en),
        .waddr (wr_idx),
        .wdata (wr_val)
    );

    for (genvar p = 1; p <= LAST; p++)
    begin : g_stage
        always_ff @(posedge clk)
        begin
            upd_idx[p] <= upd_idx[p-1];
            upd_ins[p] <= upd_ins[p-1];
            if (reset)
            begin
                upd_en[p] <= 1'b0;
            end
            else
            begin
                upd_en[p] <= upd_en[p-1];
            end
        end
    end

    // ======================================================
    // Stage 1 delta and stage 2 write
    // ======================================================

    // The read in stage 0 missed the two updates ahead of it
    // Those sit in the write stage and the stage after it now
    always_comb
    begin
        upd_delta = op_step(upd_ins[1]);
        for (int p = 2; p <= LAST; p++)
        begin
            if (upd_en[p] && (upd_idx[p] == upd_idx[1]))
            begin
                upd_delta = upd_delta + op_step(upd_ins[p]);
            end
        end
    end

    assign upd_sum = rd_val + bucket_value_t'(upd_delta);

    always_ff @(posedge clk)
    begin
        wr_val_q <= upd_sum;
    end

    assign wr_en  = upd_en[WR];
    assign wr_idx = upd_idx[WR];
    assign wr_val = wr_val_q;

    // ======================================================
    // Shadow checker
    // ======================================================

    assign shadow_cur  = shadow[wr_idx];
    assign shadow_next = shadow_cur + bucket_value_t'(op_step(upd_ins[WR]));

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int b = 0; b < `FILTER_N_BUCKETS; b++)
            begin
                shadow[b] <= '0;
            end
        end
        else if (wr_en)
        begin
            shadow[wr_idx] <= shadow_next;
        end
    end

    a_no_overflow: assert property (
        @(posedge clk) disable iff (reset) (wr_en && upd_ins[WR]) |-> (shadow_cur != '1)
    ) else $error("bucket %0d overflow on insert", wr_idx);

    a_no_underflow: assert property (
        @(posedge clk) disable iff (reset) (wr_en && !upd_ins[WR]) |-> (shadow_cur != '0)
    ) else $error("bucket %0d underflow on remove", wr_idx);

    // The bypassed value must equal a plain count of every update so far
    a_write_matches: assert property (
        @(posedge clk) disable iff (reset) wr_en |-> (wr_val == shadow_next)
    ) else $error("bucket %0d wrote %0d expected %0d", wr_idx, wr_val, shadow_next);

endmodule

//--- design/counting_filter.sv
// ==========================================================
// Counting filter top level
// Inserts and queued removes share one update pipeline. A
// value port and an is-zero port each read their own copy
// of the counters and answer two cycles after a request
// ==========================================================

`timescale 1ns/1ps

module counting_filter
    import filter_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    output logic          rdy,

    input  bucket_idx_t   test_value_req,
    output bucket_value_t t2_test_value,

    input  bucket_idx_t   test_is_zero_req,
    output logic          t2_test_is_zero,

    input  logic          insert_en,
    input  bucket_idx_t   insert,

    input  logic          remove_en,
    input  bucket_idx_t   remove,
    output logic          remove_not_full
);

    // Queue to update pipeline
    bucket_idx_t   remove_head;
    logic          remove_valid;
    logic          remove_take;

    // Shared write lines from the update pipeline
    logic          wr_en;
    bucket_idx_t   wr_idx;
    bucket_value_t wr_val;

    // The is-zero copy stores one bit that is set when the bucket is non-zero
    logic          wr_not_zero;
    logic          zero_port_not_zero;

    assign wr_not_zero     = |wr_val;
    assign t2_test_is_zero = !zero_port_not_zero;

    remove_fifo remove_queue (
        .clk       (clk),
        .reset     (reset),
        .enq_en    (remove_en),
        .enq_data  (remove),
        .not_full  (remove_not_full),
        .first     (remove_head),
        .not_empty (remove_valid),
        .deq_en    (remove_take)
    );

    // All memories sweep at the same rate, so this rdy stands for all of them
    update_pipeline upd (
        .clk          (clk),
        .reset        (reset),
        .rdy          (rdy),
        .insert_en    (insert_en),
        .insert       (insert),
        .remove_valid (remove_valid),
        .remove_head  (remove_head),
        .remove_take  (remove_take),
        .wr_en        (wr_en),
        .wr_idx       (wr_idx),
        .wr_val       (wr_val)
    );

    lookup_port #(
        .DATA_BITS ($bits(bucket_value_t))
    ) value_port (
        .clk     (clk),
        .reset   (reset),
        .rdy     (),
        .req     (test_value_req),
        .result  (t2_test_value),
        .wr_en   (wr_en),
        .wr_idx  (wr_idx),
        .wr_data (wr_val)
    );

    lookup_port #(
        .DATA_BITS (1)
    ) zero_port (
        .clk     (clk),
        .reset   (reset),
        .rdy     (),
        .req     (test_is_zero_req),
        .result  (zero_port_not_zero),
        .wr_en   (wr_en),
        .wr_idx  (wr_idx),
        .wr_data (wr_not_zero)
    );

endmodule

//--- test/counting_filter_tb.sv
// ==========================================================
// Testbench for the counting filter
// Reads one line of the stimulus file per clock cycle,
// drives inserts, removes and lookups on the rising edge and
// checks every flagged lookup two cycles later against the
// expected count and is-zero flag given in the file
// ==========================================================

`timescale 1ns/1ps
`include "filter_params.svh"

module counting_filter_tb
    import filter_pkg::*;
();

    localparam int    CLK_PERIOD     = 4;
    localparam int    RESET_CYCLES   = 16;
    localparam int    LOOKUP_LATENCY = 2;
    localparam string STIM_FILE      = "test/counting_filter_stim.txt";

    logic          clk = 1'b0;
    logic          reset;
    logic          rdy;
    bucket_idx_t   test_value_req;
    bucket_value_t t2_test_value;
    bucket_idx_t   test_is_zero_req;
    logic          t2_test_is_zero;
    logic          insert_en;
    bucket_idx_t   insert;
    logic          remove_en;
    bucket_idx_t   remove;
    logic          remove_not_full;

    // Expected results travel with the lookup until its result is due
    logic          chk_q  [LOOKUP_LATENCY+1];
    bucket_idx_t   idx_q  [LOOKUP_LATENCY+1];
    bucket_value_t val_q  [LOOKUP_LATENCY+1];
    logic          zero_q [LOOKUP_LATENCY+1];

    // Queue room seen in the previous cycle, and what was driven then
    logic          nf_seen;
    logic          ins_prev;
    logic          rem_prev;

    // Remove requests waiting in the queue during the current cycle
    int            queue_count;

    int            stim_lines;
    logic          stim_counted;

    counting_filter UUT (
        .clk              (clk),
        .reset            (reset),
        .rdy              (rdy),
        .test_value_req   (test_value_req),
        .t2_test_value    (t2_test_value),
        .test_is_zero_req (test_is_zero_req),
        .t2_test_is_zero  (t2_test_is_zero),
        .insert_en        (insert_en),
        .insert           (insert),
        .remove_en        (remove_en),
        .remove           (remove),
        .remove_not_full  (remove_not_full)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    // Lines starting with # and empty lines carry no stimulus
    function automatic logic is_data_line(input string text);
        if (text.len() == 0)
        begin
            return 1'b0;
        end
        return (text.getc(0) != "#") && (text.getc(0) != "\n");
    endfunction

    // The queue cannot be full now if it had room last cycle and did not grow.
    // It only grows when a remove was enqueued while an insert held the port
    function automatic logic remove_has_room();
        return nf_seen && !(rem_prev && ins_prev);
    endfunction

    // Drives one cycle of inputs and shifts the pending lookup checks
    task automatic drive_cycle(
        input logic          ins_en,
        input bucket_idx_t   ins_idx,
        input logic          rem_en,
        input bucket_idx_t   rem_idx,
        input bucket_idx_t   lk_idx,
        input logic          chk,
        input bucket_value_t exp_val,
        input logic          exp_zero
    );
        insert_en        <= ins_en;
        insert           <= ins_idx;
        remove_en        <= rem_en;
        remove           <= rem_idx;
        test_value_req   <= lk_idx;
        test_is_zero_req <= lk_idx;
        chk_q[0]         <= chk;
        idx_q[0]         <= lk_idx;
        val_q[0]         <= exp_val;
        zero_q[0]        <= exp_zero;
        for (int s = 1; s <= LOOKUP_LATENCY; s++)
        begin
            chk_q[s]  <= chk_q[s-1];
            idx_q[s]  <= idx_q[s-1];
            val_q[s]  <= val_q[s-1];
            zero_q[s] <= zero_q[s-1];
        end
        // Last cycle's enqueue adds one, and a cycle without an insert takes one
        queue_count = queue_count + int'(rem_prev) - int'(!ins_prev && (queue_count > 0));
        ins_prev = ins_en;
        rem_prev = rem_en;
    endtask

    // First pass over the file sizes the watchdog
    task automatic count_stim_lines();
        int    fd;
        string text;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0)
        begin
            $display("Could not open the stimulus file %s", STIM_FILE);
            $display("sim failed");
            $fatal(1, "missing stimulus file");
        end
        stim_lines = 0;
        while ($fgets(text, fd) != 0)
        begin
            if (is_data_line(text))
            begin
                stim_lines++;
            end
        end
        $fclose(fd);
        stim_counted = 1'b1;
    endtask

    initial
    begin
        int            fd;
        int            fields;
        int            rdy_low_cycles;
        string         text;
        logic          f_ins_en;
        bucket_idx_t   f_ins_idx;
        logic          f_rem_en;
        bucket_idx_t   f_rem_idx;
        bucket_idx_t   f_lk_idx;
        logic          f_chk;
        bucket_value_t f_exp_val;
        logic          f_exp_zero;

        reset            = 1'b1;
        insert_en        = 1'b0;
        insert           = '0;
        remove_en        = 1'b0;
        remove           = '0;
        test_value_req   = '0;
        test_is_zero_req = '0;
        nf_seen          = 1'b0;
        ins_prev         = 1'b0;
        rem_prev         = 1'b0;
        queue_count      = 0;
        stim_counted     = 1'b0;
        rdy_low_cycles   = 0;
        for (int s = 0; s <= LOOKUP_LATENCY; s++)
        begin
            chk_q[s]  = 1'b0;
            idx_q[s]  = '0;
            val_q[s]  = '0;
            zero_q[s] = 1'b0;
        end

        count_stim_lines();

        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        // The memories clear themselves before the filter takes requests
        @(negedge clk);
        while (rdy !== 1'b1)
        begin
            rdy_low_cycles++;
            @(negedge clk);
        end

        // The clearing sweep visits every bucket once
        assert (rdy_low_cycles == `FILTER_N_BUCKETS)
        else
        begin
            $display("Fail %0d ns: rdy was low for %0d cycles after reset, expected %0d",
                     $time, rdy_low_cycles, `FILTER_N_BUCKETS);
            $display("sim failed");
            $fatal(1, "rdy timing mismatch");
        end

        fd = $fopen(STIM_FILE, "r");
        if (fd == 0)
        begin
            $display("Could not reopen the stimulus file %s", STIM_FILE);
            $display("sim failed");
            $fatal(1, "stimulus file vanished");
        end

        while ($fgets(text, fd) != 0)
        begin
            if (is_data_line(text))
            begin
                fields = $sscanf(text, "%h %h %h %h %h %h %h %h", f_ins_en, f_ins_idx,
                                 f_rem_en, f_rem_idx, f_lk_idx, f_chk, f_exp_val, f_exp_zero);
                if (fields != 8)
                begin
                    $display("Malformed stimulus line, found %0d of 8 fields", fields);
                    $display("sim failed");
                    $fatal(1, "bad stimulus line");
                end
                @(posedge clk);
                // A remove is skipped while the queue may be full
                drive_cycle(f_ins_en, f_ins_idx, f_rem_en && remove_has_room(), f_rem_idx,
                            f_lk_idx, f_chk, f_exp_val, f_exp_zero);
            end
        end
        $fclose(fd);

        // Let the last lookups reach their check
        repeat (LOOKUP_LATENCY + 1)
        begin
            @(posedge clk);
            drive_cycle(1'b0, '0, 1'b0, '0, '0, 1'b0, '0, 1'b0);
        end
        @(posedge clk);

        $display("sim passed");
        $finish;
    end

    // Outputs are read half a cycle away from the driving edge
    always @(negedge clk)
    begin
        nf_seen = remove_not_full;
        assert (remove_not_full == (queue_count < `FILTER_REMOVE_DEPTH))
        else
        begin
            $display("Fail %0d ns: remove_not_full is %0b with %0d removes queued", $time,
                     remove_not_full, queue_count);
            $display("sim failed");
            $fatal(1, "remove queue back-pressure mismatch");
        end
    end

    always @(negedge clk)
    begin
        if (chk_q[LOOKUP_LATENCY])
        begin
            assert (t2_test_value == val_q[LOOKUP_LATENCY])
            else
            begin
                $display("Fail %0d ns: value of bucket %0h is %0h, expected %0h", $time,
                         idx_q[LOOKUP_LATENCY], t2_test_value, val_q[LOOKUP_LATENCY]);
                $display("sim failed");
                $fatal(1, "value lookup mismatch");
            end
            assert (t2_test_is_zero == zero_q[LOOKUP_LATENCY])
            else
            begin
                $display("Fail %0d ns: is-zero of bucket %0h is %0b, expected %0b", $time,
                         idx_q[LOOKUP_LATENCY], t2_test_is_zero, zero_q[LOOKUP_LATENCY]);
                $display("sim failed");
                $fatal(1, "is-zero lookup mismatch");
            end
        end
    end

    // Allows every stimulus line plus a margin for reset and the clearing sweep
    initial
    begin
        wait (stim_counted);
        #((stim_lines + 100) * CLK_PERIOD);
        $display("Watchdog expired, the run did not end within %0d cycles", stim_lines + 100);
        $display("sim failed");
        $fatal(1, "watchdog timeout");
    end

endmodule

//--- counting_filter.f
+incdir+include
design/filter_pkg.sv
design/storage_pkg.sv
design/bucket_ram.sv
design/remove_fifo.sv
design/lookup_port.sv
design/update_pipeline.sv
design/counting_filter.sv
test/counting_filter_tb.sv

//--- Makefile
# Verilator build, run and lint of the counting filter testbench
# The simulation exits with a non-zero status when a check fails

TOP := counting_filter_tb

.PHONY: all run lint clean

all: run

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): counting_filter.f design/*.sv include/*.svh test/*.sv test/*.txt
	verilator --binary --assert --timing --timescale 1ns/1ps -Wno-fatal \
		--top-module $(TOP) -f counting_filter.f

lint:
	verilator --lint-only -Wall --assert --timing --timescale 1ns/1ps \
		--top-module $(TOP) -f counting_filter.f

clean:
	rm -rf obj_dir

//--- test/counting_filter_stim.txt
# Columns: insert_en insert_idx remove_en remove_idx lookup_idx check expected_value expected_is_zero
# One line per clock cycle after rdy, every field in hex
0 0 0 0 0 1 0 1
0 0 0 0 1 1 0 1
0 0 0 0 2 1 0 1
0 0 0 0 3 1 0 1
0 0 0 0 4 1 0 1
0 0 0 0 5 1 0 1
0 0 0 0 6 1 0 1
0 0 0 0 7 1 0 1
0 0 0 0 8 1 0 1
0 0 0 0 9 1 0 1
0 0 0 0 a 1 0 1
0 0 0 0 b 1 0 1
0 0 0 0 c 1 0 1
0 0 0 0 d 1 0 1
0 0 0 0 e 1 0 1
0 0 0 0 f 1 0 1
1 3 0 0 3 1 0 1
1 3 0 0 3 1 1 0
1 3 0 0 3 1 2 0
1 3 0 0 3 1 3 0
0 0 0 0 3 1 4 0
1 5 0 0 0 1 0 1
1 a 0 0 5 1 1 0
1 5 0 0 a 1 1 0
1 a 0 0 5 1 2 0
1 5 0 0 a 1 2 0
1 c 0 0 5 1 3 0
0 0 0 0 c 1 1 0
0 0 0 0 7 1 0 1
0 0 0 0 3 1 4 0
0 0 1 5 3 1 4 0
0 0 1 5 0 1 0 1
0 0 1 c 3 1 4 0
0 0 1 a 7 1 0 1
0 0 0 0 3 1 4 0
0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0
0 0 0 0 f 1 0 1
0 0 0 0 0 0 0 0
0 0 0 0 5 1 1 0
0 0 0 0 c 1 0 1
0 0 0 0 a 1 1 0
0 0 0 0 3 1 4 0
1 9 1 3 0 0 0 0
1 e 0 0 9 1 1 0
1 9 1 9 0 0 0 0
1 e 0 0 3 1 4 0
1 9 1 3 0 0 0 0
1 e 0 0 0 0 0 0
1 9 1 e 0 0 0 0
1 e 0 0 e 1 3 0
1 9 1 3 0 0 0 0
1 e 0 0 3 1 4 0
1 9 1 3 0 0 0 0
1 e 0 0 9 1 6 0
0 0 0 0 a 1 1 0
0 0 0 0 0 0 0 0
0 0 0 0 c 1 0 1
0 0 0 0 0 0 0 0
0 0 0 0 5 1 1 0
0 0 0 0 0 0 0 0
0 0 0 0 3 1 2 0
0 0 0 0 9 1 5 0
0 0 0 0 e 1 5 0
0 0 0 0 0 1 0 1
